// ==== design/cpu_bram_pkg.sv ====
/*
 * CPU BRAM package
 * Target select encoding, controller register map, memory sizes and the
 * packed structs that carry writes and control values between blocks
 */
package cpu_bram_pkg;

  // CPU address and data layout
  localparam int CPU_ADDR_W = 17;
  localparam int BUS_ADDR_W = 14;
  localparam int BUS_DATA_W = 16;
  localparam int MEM_ADDR_W = 16;

  // Segment widths, prepended above the word address
  localparam int MOD_SEG_BITS = 1;
  localparam int STM_SEG_BITS = 2;

  // Memory depths in words
  localparam int MOD_DEPTH = 2 ** (MOD_SEG_BITS + BUS_ADDR_W);
  localparam int NORMAL_DEPTH = 512;
  localparam int STM_DEPTH = 2 ** (STM_SEG_BITS + BUS_ADDR_W);

  // Target select from address bits 16..15
  typedef enum logic [1:0] {
    BRAM_SEL_CONTROLLER = 2'd0,
    BRAM_SEL_MOD        = 2'd1,
    BRAM_SEL_NORMAL     = 2'd2,
    BRAM_SEL_STM        = 2'd3
  } bram_sel_e;

  // Controller register map
  localparam logic [BUS_ADDR_W-1:0] ADDR_CTL_REG = 14'd0;
  localparam logic [BUS_ADDR_W-1:0] ADDR_MOD_MEM_SEGMENT = 14'd1;
  localparam logic [BUS_ADDR_W-1:0] ADDR_STM_MEM_SEGMENT = 14'd2;
  localparam logic [BUS_ADDR_W-1:0] ADDR_MOD_CYCLE = 14'd3;
  localparam logic [BUS_ADDR_W-1:0] ADDR_SILENT_STEP = 14'd4;
  localparam logic [BUS_ADDR_W-1:0] ADDR_STM_CYCLE = 14'd5;

  // Bits of the control register
  localparam int CTL_REG_FORCE_FAN_BIT = 0;
  localparam int CTL_REG_SYNC_BIT = 1;

  // One decoded bus write, 32 bits
  typedef struct packed {
    bram_sel_e              sel;
    logic [BUS_ADDR_W-1:0]  addr;
    logic [BUS_DATA_W-1:0]  data;
  } bus_write_t;

  // Write into one memory, address already carries the segment
  typedef struct packed {
    logic [MEM_ADDR_W-1:0]  addr;
    logic [BUS_DATA_W-1:0]  data;
  } mem_write_t;

  // Control values for the rest of the chip, 50 bits
  typedef struct packed {
    logic                   force_fan;
    logic                   sync;
    logic [BUS_DATA_W-1:0]  mod_cycle;
    logic [BUS_DATA_W-1:0]  silent_step;
    logic [BUS_DATA_W-1:0]  stm_cycle;
  } ctl_out_t;

endpackage

// ==== design/cpu_bus_capture.sv ====
/*
 * CPU bus capture
 * Samples the SRAM-style CPU pins and emits a single write strobe at the
 * start of each phase where chip select and write enable are both low
 */
module cpu_bus_capture (
  input  logic                                 CPU_CKIO,
  input  logic                                 rst,
  input  logic [cpu_bram_pkg::CPU_ADDR_W-1:0]  cpu_addr,
  input  logic [cpu_bram_pkg::BUS_DATA_W-1:0]  cpu_data,
  input  logic                                 cpu_cs1_n,
  input  logic                                 cpu_we0_n,
  output logic                                 wr_stb,
  output cpu_bram_pkg::bus_write_t             wr
);

  logic [cpu_bram_pkg::CPU_ADDR_W-1:0] addr_q;
  logic [cpu_bram_pkg::BUS_DATA_W-1:0] data_q;
  logic cs_n_q;
  logic we_n_q;
  logic wr_active;
  logic wr_active_q;
  logic wr_start;

  assign wr_active = ~cs_n_q & ~we_n_q;
  // Rising edge of the active phase, so a long WE low gives one write
  assign wr_start = wr_active & ~wr_active_q;

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      cs_n_q <= 1'b1;
      we_n_q <= 1'b1;
      wr_active_q <= 1'b0;
      wr_stb <= 1'b0;
    end else begin
      cs_n_q <= cpu_cs1_n;
      we_n_q <= cpu_we0_n;
      wr_active_q <= wr_active;
      wr_stb <= wr_start;
    end
  end

  // Address bit 0 is a byte lane and not used
  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data;
    if (wr_start) begin
      wr.sel <= cpu_bram_pkg::bram_sel_e'(addr_q[16:15]);
      wr.addr <= addr_q[14:1];
      wr.data <= data_q;
    end
  end

endmodule

// ==== design/bram_router.sv ====
/*
 * BRAM router
 * Steers each bus write to the register file or one of the three memories,
 * adding the segment number for the modulation and STM memories, and
 * selects and registers the readback data
 */
module bram_router (
  input  logic                                   CPU_CKIO,
  input  logic                                   rst,
  input  logic                                   wr_stb,
  input  cpu_bram_pkg::bus_write_t               wr,
  input  logic [cpu_bram_pkg::MOD_SEG_BITS-1:0]  mod_seg,
  input  logic [cpu_bram_pkg::STM_SEG_BITS-1:0]  stm_seg,
  output logic                                   reg_stb,
  output cpu_bram_pkg::bus_write_t               reg_wr,
  output logic                                   mod_stb,
  output logic                                   normal_stb,
  output logic                                   stm_stb,
  output cpu_bram_pkg::mem_write_t               mem_wr,
  input  logic                                   rd_stb,
  input  cpu_bram_pkg::bram_sel_e                rd_sel,
  input  logic [cpu_bram_pkg::MEM_ADDR_W-1:0]    rd_addr,
  output logic [cpu_bram_pkg::BUS_ADDR_W-1:0]    reg_rd_addr,
  input  logic [cpu_bram_pkg::BUS_DATA_W-1:0]    reg_rd_data,
  input  logic [cpu_bram_pkg::BUS_DATA_W-1:0]    mod_rd_data,
  input  logic [cpu_bram_pkg::BUS_DATA_W-1:0]    normal_rd_data,
  input  logic [cpu_bram_pkg::BUS_DATA_W-1:0]    stm_rd_data,
  output logic [cpu_bram_pkg::MEM_ADDR_W-1:0]    mem_rd_addr,
  output logic                                   rd_valid,
  output logic [cpu_bram_pkg::BUS_DATA_W-1:0]    rd_data
);

  localparam int MOD_PAD = cpu_bram_pkg::MEM_ADDR_W - cpu_bram_pkg::MOD_SEG_BITS
                           - cpu_bram_pkg::BUS_ADDR_W;
  localparam int NORMAL_PAD = cpu_bram_pkg::MEM_ADDR_W - cpu_bram_pkg::BUS_ADDR_W;

  cpu_bram_pkg::bram_sel_e rd_sel_q;
  logic rd_pend_q;

  // Write strobe decode
  always_comb begin
    reg_stb = 1'b0;
    mod_stb = 1'b0;
    normal_stb = 1'b0;
    stm_stb = 1'b0;
    case (wr.sel)
      cpu_bram_pkg::BRAM_SEL_CONTROLLER: reg_stb = wr_stb;
      cpu_bram_pkg::BRAM_SEL_MOD:        mod_stb = wr_stb;
      cpu_bram_pkg::BRAM_SEL_NORMAL:     normal_stb = wr_stb;
      cpu_bram_pkg::BRAM_SEL_STM:        stm_stb = wr_stb;
      default: ;
    endcase
  end

  assign reg_wr = wr;

  // Memory address gets the segment above the word address
  always_comb begin
    mem_wr.data = wr.data;
    case (wr.sel)
      cpu_bram_pkg::BRAM_SEL_MOD:
        mem_wr.addr = {{MOD_PAD{1'b0}}, mod_seg, wr.addr};
      cpu_bram_pkg::BRAM_SEL_STM:
        mem_wr.addr = {stm_seg, wr.addr};
      default:
        mem_wr.addr = {{NORMAL_PAD{1'b0}}, wr.addr};
    endcase
  end

  // Read address goes straight to all sources
  assign reg_rd_addr = rd_addr[cpu_bram_pkg::BUS_ADDR_W-1:0];
  assign mem_rd_addr = rd_addr;

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      rd_pend_q <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_pend_q <= rd_stb;
      rd_valid <= rd_pend_q;
    end
  end

  // Select follows the source read latency by one cycle
  always_ff @(posedge CPU_CKIO) begin
    rd_sel_q <= rd_sel;
    case (rd_sel_q)
      cpu_bram_pkg::BRAM_SEL_CONTROLLER: rd_data <= reg_rd_data;
      cpu_bram_pkg::BRAM_SEL_MOD:        rd_data <= mod_rd_data;
      cpu_bram_pkg::BRAM_SEL_NORMAL:     rd_data <= normal_rd_data;
      default:                           rd_data <= stm_rd_data;
    endcase
  end

endmodule

// ==== design/ctrl_regfile.sv ====
/*
 * Controller register file
 * Control word, memory segment numbers, cycle counts and silencer step,
 * written from the CPU bus and read back with one cycle of latency
 */
module ctrl_regfile (
  input  logic                                   CPU_CKIO,
  input  logic                                   rst,
  input  logic                                   reg_stb,
  input  cpu_bram_pkg::bus_write_t               reg_wr,
  input  logic [cpu_bram_pkg::BUS_ADDR_W-1:0]    rd_addr,
  output logic [cpu_bram_pkg::BUS_DATA_W-1:0]    rd_data,
  output cpu_bram_pkg::ctl_out_t                 ctl_out,
  output logic [cpu_bram_pkg::MOD_SEG_BITS-1:0]  mod_seg,
  output logic [cpu_bram_pkg::STM_SEG_BITS-1:0]  stm_seg
);

  localparam int MOD_SEG_PAD = cpu_bram_pkg::BUS_DATA_W - cpu_bram_pkg::MOD_SEG_BITS;
  localparam int STM_SEG_PAD = cpu_bram_pkg::BUS_DATA_W - cpu_bram_pkg::STM_SEG_BITS;

  logic [cpu_bram_pkg::BUS_DATA_W-1:0] ctl_reg;
  logic [cpu_bram_pkg::BUS_DATA_W-1:0] mod_cycle;
  logic [cpu_bram_pkg::BUS_DATA_W-1:0] silent_step;
  logic [cpu_bram_pkg::BUS_DATA_W-1:0] stm_cycle;

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      ctl_reg <= '0;
      mod_seg <= '0;
      stm_seg <= '0;
      mod_cycle <= '0;
      silent_step <= '0;
      stm_cycle <= '0;
    end else if (reg_stb) begin
      case (reg_wr.addr)
        cpu_bram_pkg::ADDR_CTL_REG:
          ctl_reg <= reg_wr.data;
        cpu_bram_pkg::ADDR_MOD_MEM_SEGMENT:
          mod_seg <= reg_wr.data[cpu_bram_pkg::MOD_SEG_BITS-1:0];
        cpu_bram_pkg::ADDR_STM_MEM_SEGMENT:
          stm_seg <= reg_wr.data[cpu_bram_pkg::STM_SEG_BITS-1:0];
        cpu_bram_pkg::ADDR_MOD_CYCLE:
          mod_cycle <= reg_wr.data;
        cpu_bram_pkg::ADDR_SILENT_STEP:
          silent_step <= reg_wr.data;
        cpu_bram_pkg::ADDR_STM_CYCLE:
          stm_cycle <= reg_wr.data;
        default: ;
      endcase
    end
  end

  // Unmapped addresses read as zero
  always_ff @(posedge CPU_CKIO) begin
    case (rd_addr)
      cpu_bram_pkg::ADDR_CTL_REG:         rd_data <= ctl_reg;
      cpu_bram_pkg::ADDR_MOD_MEM_SEGMENT: rd_data <= {{MOD_SEG_PAD{1'b0}}, mod_seg};
      cpu_bram_pkg::ADDR_STM_MEM_SEGMENT: rd_data <= {{STM_SEG_PAD{1'b0}}, stm_seg};
      cpu_bram_pkg::ADDR_MOD_CYCLE:       rd_data <= mod_cycle;
      cpu_bram_pkg::ADDR_SILENT_STEP:     rd_data <= silent_step;
      cpu_bram_pkg::ADDR_STM_CYCLE:       rd_data <= stm_cycle;
      default:                            rd_data <= '0;
    endcase
  end

  always_comb begin
    ctl_out.force_fan = ctl_reg[cpu_bram_pkg::CTL_REG_FORCE_FAN_BIT];
    ctl_out.sync = ctl_reg[cpu_bram_pkg::CTL_REG_SYNC_BIT];
    ctl_out.mod_cycle = mod_cycle;
    ctl_out.silent_step = silent_step;
    ctl_out.stm_cycle = stm_cycle;
  end

endmodule

// ==== design/bram_sp.sv ====
/*
 * Block RAM, one write port and one registered read port
 */
module bram_sp #(
  parameter int DEPTH = 512,
  parameter int WIDTH = 16
) (
  input  logic                      CPU_CKIO,
  input  logic                      wr_stb,
  input  logic [$clog2(DEPTH)-1:0]  wr_addr,
  input  logic [WIDTH-1:0]          wr_data,
  input  logic [$clog2(DEPTH)-1:0]  rd_addr,
  output logic [WIDTH-1:0]          rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge CPU_CKIO) begin
    if (wr_stb) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // One cycle read latency
  always_ff @(posedge CPU_CKIO) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== design/cpu_bram_top.sv ====
/*
 * CPU BRAM subsystem top
 * CPU bus capture, write router, controller register file and the
 * modulation, normal and STM memories
 */
module cpu_bram_top (
  input  logic                                 CPU_CKIO,
  input  logic                                 rst,
  input  logic [cpu_bram_pkg::CPU_ADDR_W-1:0]  cpu_addr,
  input  logic [cpu_bram_pkg::BUS_DATA_W-1:0]  cpu_data,
  input  logic                                 cpu_cs1_n,
  input  logic                                 cpu_we0_n,
  input  logic                                 rd_stb,
  input  cpu_bram_pkg::bram_sel_e              rd_sel,
  input  logic [cpu_bram_pkg::MEM_ADDR_W-1:0]  rd_addr,
  output logic                                 rd_valid,
  output logic [cpu_bram_pkg::BUS_DATA_W-1:0]  rd_data,
  output cpu_bram_pkg::ctl_out_t               ctl_out
);

  localparam int MOD_AW = $clog2(cpu_bram_pkg::MOD_DEPTH);
  localparam int NORMAL_AW = $clog2(cpu_bram_pkg::NORMAL_DEPTH);
  localparam int STM_AW = $clog2(cpu_bram_pkg::STM_DEPTH);

  logic wr_stb;
  cpu_bram_pkg::bus_write_t bus_wr;
  logic reg_stb;
  cpu_bram_pkg::bus_write_t reg_wr;
  logic mod_stb;
  logic normal_stb;
  logic stm_stb;
  cpu_bram_pkg::mem_write_t mem_wr;
  logic [cpu_bram_pkg::MOD_SEG_BITS-1:0] mod_seg;
  logic [cpu_bram_pkg::STM_SEG_BITS-1:0] stm_seg;
  logic [cpu_bram_pkg::BUS_ADDR_W-1:0] reg_rd_addr;
  logic [cpu_bram_pkg::BUS_DATA_W-1:0] reg_rd_data;
  logic [cpu_bram_pkg::BUS_DATA_W-1:0] mod_rd_data;
  logic [cpu_bram_pkg::BUS_DATA_W-1:0] normal_rd_data;
  logic [cpu_bram_pkg::BUS_DATA_W-1:0] stm_rd_data;
  logic [cpu_bram_pkg::MEM_ADDR_W-1:0] mem_rd_addr;

  cpu_bus_capture u_cpu_bus_capture (
    .CPU_CKIO, .rst, .cpu_addr, .cpu_data, .cpu_cs1_n, .cpu_we0_n,
    .wr_stb, .wr(bus_wr)
  );

  bram_router u_bram_router (
    .CPU_CKIO, .rst, .wr_stb, .wr(bus_wr), .mod_seg, .stm_seg,
    .reg_stb, .reg_wr, .mod_stb, .normal_stb, .stm_stb, .mem_wr,
    .rd_stb, .rd_sel, .rd_addr, .reg_rd_addr, .reg_rd_data,
    .mod_rd_data, .normal_rd_data, .stm_rd_data, .mem_rd_addr,
    .rd_valid, .rd_data
  );

  ctrl_regfile u_ctrl_regfile (
    .CPU_CKIO, .rst, .reg_stb, .reg_wr, .rd_addr(reg_rd_addr),
    .rd_data(reg_rd_data), .ctl_out, .mod_seg, .stm_seg
  );

  // Narrower memories take the low address bits
  bram_sp #(.DEPTH(cpu_bram_pkg::MOD_DEPTH), .WIDTH(cpu_bram_pkg::BUS_DATA_W)) u_mod_mem (
    .CPU_CKIO, .wr_stb(mod_stb), .wr_addr(mem_wr.addr[MOD_AW-1:0]),
    .wr_data(mem_wr.data), .rd_addr(mem_rd_addr[MOD_AW-1:0]), .rd_data(mod_rd_data)
  );

  bram_sp #(.DEPTH(cpu_bram_pkg::NORMAL_DEPTH), .WIDTH(cpu_bram_pkg::BUS_DATA_W)) u_normal_mem (
    .CPU_CKIO, .wr_stb(normal_stb), .wr_addr(mem_wr.addr[NORMAL_AW-1:0]),
    .wr_data(mem_wr.data), .rd_addr(mem_rd_addr[NORMAL_AW-1:0]), .rd_data(normal_rd_data)
  );

  bram_sp #(.DEPTH(cpu_bram_pkg::STM_DEPTH), .WIDTH(cpu_bram_pkg::BUS_DATA_W)) u_stm_mem (
    .CPU_CKIO, .wr_stb(stm_stb), .wr_addr(mem_wr.addr[STM_AW-1:0]),
    .wr_data(mem_wr.data), .rd_addr(mem_rd_addr[STM_AW-1:0]), .rd_data(stm_rd_data)
  );

endmodule

// ==== tests/bram_checker.sv ====
/*
 * Result checker for the CPU BRAM testbench
 * Queues expected readback values, matches them against rd_valid/rd_data
 * in order and compares ctl_out fields on request
 */
module bram_checker (
  input  logic                    CPU_CKIO,
  input  logic                    exp_rd_stb,
  input  logic [15:0]             exp_rd_data,
  input  int                      exp_case,
  input  logic                    exp_ctl_stb,
  input  logic [13:0]             exp_ctl_addr,
  input  logic [15:0]             exp_ctl_data,
  input  logic                    rd_valid,
  input  logic [15:0]             rd_data,
  input  cpu_bram_pkg::ctl_out_t  ctl_out,
  output int                      pending,
  output int                      pass_cnt,
  output int                      fail_cnt
);

  localparam int RD_TIMEOUT = 20;

  logic [15:0] exp_q[$];
  int case_q[$];
  int push_cnt = 0;
  int done_cnt = 0;
  int rd_pass = 0;
  int rd_fail = 0;
  int ctl_pass = 0;
  int ctl_fail = 0;

  assign pending = push_cnt - done_cnt;
  assign pass_cnt = rd_pass + ctl_pass;
  assign fail_cnt = rd_fail + ctl_fail;

  always @(posedge CPU_CKIO) begin
    if (exp_rd_stb) begin
      exp_q.push_back(exp_rd_data);
      case_q.push_back(exp_case);
      push_cnt = push_cnt + 1;
    end
  end

  // Results come back in request order
  initial begin : read_watch
    int cycles;
    int case_no;
    logic [15:0] want;
    forever begin
      @(negedge CPU_CKIO);
      if (exp_q.size() != 0) begin
        cycles = 0;
        while (!rd_valid && cycles < RD_TIMEOUT) begin
          @(negedge CPU_CKIO);
          cycles++;
        end
        want = exp_q.pop_front();
        case_no = case_q.pop_front();
        if (!rd_valid) begin
          $display("case %0d: timeout waiting for rd_valid", case_no);
          rd_fail++;
        end else if (rd_data !== want) begin
          $display("** Error @ %0t: case %0d read 0x%04h, expected 0x%04h",
                   $time, case_no, rd_data, want);
          rd_fail++;
        end else begin
          $display("case %0d: read 0x%04h ok", case_no, rd_data);
          rd_pass++;
        end
        done_cnt++;
      end else if (rd_valid) begin
        $display("rd_valid raised at %0t with no read outstanding", $time);
        rd_fail++;
      end
    end
  end

  always @(negedge CPU_CKIO) begin : ctl_watch
    logic [15:0] got;
    logic [15:0] want;
    logic known;
    got = '0;
    want = exp_ctl_data;
    known = 1'b1;
    if (exp_ctl_stb) begin
      case (exp_ctl_addr)
        // Only the two flag bits of the control word reach ctl_out
        cpu_bram_pkg::ADDR_CTL_REG: begin
          got[cpu_bram_pkg::CTL_REG_FORCE_FAN_BIT] = ctl_out.force_fan;
          got[cpu_bram_pkg::CTL_REG_SYNC_BIT] = ctl_out.sync;
          want = exp_ctl_data & 16'h0003;
        end
        cpu_bram_pkg::ADDR_MOD_CYCLE:   got = ctl_out.mod_cycle;
        cpu_bram_pkg::ADDR_SILENT_STEP: got = ctl_out.silent_step;
        cpu_bram_pkg::ADDR_STM_CYCLE:   got = ctl_out.stm_cycle;
        default: known = 1'b0;
      endcase
      if (!known) begin
        $display("case %0d: no ctl_out field for register 0x%04h", exp_case, exp_ctl_addr);
        ctl_fail++;
      end else if (got !== want) begin
        $display("** Error @ %0t: case %0d ctl_out reg 0x%04h is 0x%04h, expected 0x%04h",
                 $time, exp_case, exp_ctl_addr, got, want);
        ctl_fail++;
      end else begin
        $display("case %0d: ctl_out reg 0x%04h = 0x%04h ok", exp_case, exp_ctl_addr, got);
        ctl_pass++;
      end
    end
  end

endmodule

// ==== tests/tb_cpu_bram.sv ====
/*
 * Testbench for the CPU BRAM subsystem
 * Runs the cases of tests/bram_cases.txt as CPU bus writes, readback
 * requests and ctl_out checks, with bram_checker judging the results
 */
module tb_cpu_bram;

  localparam int DRAIN_TIMEOUT = 100;

  logic CPU_CKIO;
  logic rst;
  logic [cpu_bram_pkg::CPU_ADDR_W-1:0] cpu_addr;
  logic [15:0] cpu_data;
  logic cpu_cs1_n;
  logic cpu_we0_n;
  logic rd_stb;
  cpu_bram_pkg::bram_sel_e rd_sel;
  logic [15:0] rd_addr;
  logic rd_valid;
  logic [15:0] rd_data;
  cpu_bram_pkg::ctl_out_t ctl_out;

  logic exp_rd_stb;
  logic [15:0] exp_rd_data;
  int exp_case;
  logic exp_ctl_stb;
  logic [13:0] exp_ctl_addr;
  logic [15:0] exp_ctl_data;
  int pending;
  int pass_cnt;
  int fail_cnt;

  int fd;
  int case_no;
  int test_cnt;
  logic rd_open;
  logic abort;

  cpu_bram_top u_cpu_bram_top (
    .CPU_CKIO, .rst, .cpu_addr, .cpu_data, .cpu_cs1_n, .cpu_we0_n,
    .rd_stb, .rd_sel, .rd_addr, .rd_valid, .rd_data, .ctl_out
  );

  bram_checker u_bram_checker (
    .CPU_CKIO, .exp_rd_stb, .exp_rd_data, .exp_case, .exp_ctl_stb, .exp_ctl_addr,
    .exp_ctl_data, .rd_valid, .rd_data, .ctl_out, .pending, .pass_cnt, .fail_cnt
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #2 CPU_CKIO = ~CPU_CKIO;
  end

  initial begin
    #40000;
    $display("simulation time limit reached");
    $display("test failed");
    $finish;
  end

  // SRAM-style write cycle with WE held low for two cycles
  task automatic bus_write(input logic [1:0] sel, input logic [13:0] waddr,
                           input logic [15:0] wdata, input logic cs_high);
    @(posedge CPU_CKIO);
    #1;
    cpu_addr = {sel, waddr, 1'b0};
    cpu_data = wdata;
    cpu_cs1_n = cs_high;
    @(posedge CPU_CKIO);
    #1;
    cpu_we0_n = 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    #1;
    cpu_we0_n = 1'b1;
    @(posedge CPU_CKIO);
    #1;
    cpu_cs1_n = 1'b1;
    // Strobe and target write are done two edges later
    repeat (2) @(posedge CPU_CKIO);
  endtask

  task automatic issue_read(input logic [1:0] sel, input logic [15:0] raddr,
                            input logic [15:0] want);
    @(posedge CPU_CKIO);
    #1;
    rd_stb = 1'b1;
    rd_sel = cpu_bram_pkg::bram_sel_e'(sel);
    rd_addr = raddr;
    exp_rd_stb = 1'b1;
    exp_rd_data = want;
    exp_case = case_no;
    rd_open = 1'b1;
  endtask

  task automatic finish_reads();
    int cycles;
    @(posedge CPU_CKIO);
    #1;
    rd_stb = 1'b0;
    exp_rd_stb = 1'b0;
    rd_open = 1'b0;
    cycles = 0;
    while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge CPU_CKIO);
      cycles++;
    end
    if (pending != 0) begin
      $display("timeout waiting for the checker to finish %0d reads", pending);
      abort = 1'b1;
    end
  endtask

  task automatic check_ctl(input logic [13:0] reg_addr, input logic [15:0] want);
    @(posedge CPU_CKIO);
    #1;
    exp_ctl_stb = 1'b1;
    exp_ctl_addr = reg_addr;
    exp_ctl_data = want;
    exp_case = case_no;
    @(posedge CPU_CKIO);
    #1;
    exp_ctl_stb = 1'b0;
  endtask

  task automatic skip_line();
    int c;
    c = $fgetc(fd);
    // 10 is newline
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic run_case(input logic [7:0] op, input int sel, input logic [15:0] addr,
                          input logic [15:0] val);
    if (op != "R" && rd_open) begin
      finish_reads();
    end
    case (op)
      "W": begin
        repeat ($urandom_range(0, 2)) @(posedge CPU_CKIO);
        bus_write(sel[1:0], addr[13:0], val, sel[2]);
      end
      "R": begin
        test_cnt++;
        issue_read(sel[1:0], addr, val);
      end
      "C": begin
        test_cnt++;
        check_ctl(addr[13:0], val);
      end
      default: begin
        $display("case %0d: unknown opcode %c in the case file", case_no, op);
        abort = 1'b1;
      end
    endcase
  endtask

  initial begin : main
    logic [7:0] op;
    int sel;
    logic [15:0] addr;
    logic [15:0] val;
    int n;
    logic eof;
    void'($urandom(95959));
    rst = 1'b1;
    cpu_addr = '0;
    cpu_data = '0;
    cpu_cs1_n = 1'b1;
    cpu_we0_n = 1'b1;
    rd_stb = 1'b0;
    rd_sel = cpu_bram_pkg::BRAM_SEL_CONTROLLER;
    rd_addr = '0;
    exp_rd_stb = 1'b0;
    exp_rd_data = '0;
    exp_case = 0;
    exp_ctl_stb = 1'b0;
    exp_ctl_addr = '0;
    exp_ctl_data = '0;
    case_no = 0;
    test_cnt = 0;
    rd_open = 1'b0;
    abort = 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    #1;
    rst = 1'b0;
    fd = $fopen("tests/bram_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/bram_cases.txt");
      abort = 1'b1;
    end
    eof = (fd == 0);
    while (!eof && !abort) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1) begin
        eof = 1'b1;
      end else if (op == "#") begin
        skip_line();
      end else begin
        n = $fscanf(fd, "%d %h %h", sel, addr, val);
        case_no++;
        if (n != 3) begin
          $display("case %0d: malformed line in the case file", case_no);
          abort = 1'b1;
        end else begin
          run_case(op, sel, addr, val);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (rd_open) begin
      finish_reads();
    end
    repeat (2) @(posedge CPU_CKIO);
    $display("checks: %0d expected, %0d passed, %0d failed", test_cnt, pass_cnt, fail_cnt);
    if (!abort && fail_cnt == 0 && pass_cnt == test_cnt) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tests/bram_cases.txt ====
# op sel addr data: W writes word addr of target sel (sel+4 holds chip select high),
# R reads full memory addr of target sel and expects data, C checks ctl_out field of reg addr
C 0 0000 0000
C 0 0003 0000
C 0 0004 0000
C 0 0005 0000
# Normal memory
W 2 0010 1234
W 2 0011 abcd
W 2 01ff 5a5a
R 2 0010 1234
R 2 0011 abcd
R 2 01ff 5a5a
# Modulation segments 0 and 1
W 1 0020 1111
W 0 0001 0001
W 1 0020 2222
R 0 0001 0001
R 1 0020 1111
R 1 4020 2222
W 0 0001 0000
W 1 0021 3333
R 1 0021 3333
# STM segment 3 above segment 0
W 3 0100 aaaa
W 0 0002 0003
W 3 0100 bbbb
R 3 0100 aaaa
R 3 c100 bbbb
R 0 0002 0003
# Control outputs and register readback
W 0 0000 0003
C 0 0000 0003
W 0 0000 0002
C 0 0000 0002
W 0 0003 07d0
W 0 0004 0010
W 0 0005 1388
C 0 0003 07d0
C 0 0004 0010
C 0 0005 1388
W 0 0006 ffff
R 0 0000 0002
R 0 0003 07d0
R 0 0006 0000
# Chip select held high leaves the word alone
W 6 0010 ffff
R 2 0010 1234
# Burst across all targets
R 2 0011 abcd
R 1 4020 2222
R 3 c100 bbbb
R 0 0005 1388
R 0 0001 0000

// ==== compile.f ====
design/cpu_bram_pkg.sv
design/cpu_bus_capture.sv
design/bram_router.sv
design/ctrl_regfile.sv
design/bram_sp.sv
design/cpu_bram_top.sv
tests/bram_checker.sv
tests/tb_cpu_bram.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_cpu_bram \
  && ./obj_dir/Vtb_cpu_bram | tee /dev/stderr | grep -x "test passed" > /dev/null \
  && echo "simulation run passed" \
  || { echo "simulation run failed"; exit 1; }
